// ==== sim.f ====
+incdir+include
logic/icache_pkg.sv
logic/icache_fsm.sv
logic/refill_counter.sv
logic/tag_array.sv
logic/plru_tree.sv
logic/line_data_ram.sv
logic/icache_top.sv
sim/l2_model.sv
sim/tb_icache.sv

// ==== sim/tb_icache.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module tb_icache;

    localparam int TIMEOUT = 200;  // cycles allowed per wait

    logic                      ACLK, ARESETn, req_valid, req_ready, rsp_valid, rsp_ready, busy;
    logic                      l2_ar_valid, l2_ar_ready, l2_r_valid, l2_r_last, l2_r_ready;
    logic                      exp_hit, in_flight;
    logic [`ICACHE_ADDR_W-1:0] l2_ar_addr, exp_line;
    logic [`ICACHE_DATA_W-1:0] l2_r_data, exp_data;
    icache_pkg::cpu_req_t      req;
    icache_pkg::cpu_rsp_t      rsp;
    int                        ar_count;
    int                        errors = 0;
    int                        err_mark = 0;
    int                        requests = 0;
    int                        tests = 0;
    string                     test_name = "reset";
    logic [15:0]               lfsr = 16'd15;

    // reference tags, valid bits and plru trees
    logic [`ICACHE_TAG_W-1:0]  ref_tag [`ICACHE_SETS][`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]   ref_valid [`ICACHE_SETS] = '{default: '0};
    logic [2:0]                ref_tree [`ICACHE_SETS] = '{default: '0};

    icache_top u_dut (.ACLK, .ARESETn, .req_valid, .req, .req_ready, .rsp_valid, .rsp,
        .rsp_ready, .busy, .l2_ar_valid, .l2_ar_addr, .l2_ar_ready, .l2_r_valid, .l2_r_data,
        .l2_r_last, .l2_r_ready);

    l2_model u_l2 (.ACLK, .ar_valid(l2_ar_valid), .ar_addr(l2_ar_addr), .ar_ready(l2_ar_ready),
        .r_valid(l2_r_valid), .r_data(l2_r_data), .r_last(l2_r_last));

    initial begin
        ACLK = 1'b0;
        forever #4 ACLK = ~ACLK;
    end

    // request in flight and L2 requests seen for it
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            in_flight <= 1'b0;
            ar_count  <= 0;
        end else begin
            if (req_valid && req_ready) begin
                in_flight <= 1'b1;
                ar_count  <= 0;
            end else if (l2_ar_valid && l2_ar_ready) begin
                ar_count <= ar_count + 1;
            end
            if (rsp_valid && rsp_ready) in_flight <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic count_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // galois lfsr, stepped once for every bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
        end
        return v;
    endfunction

    function automatic logic [31:0] slice_of(input logic [31:0] addr,
                                             input icache_pkg::access_size_e size);
        logic [31:0] word;
        word = ~{addr[31:2], 2'b00} >> (8 * addr[1:0]);  // wanted lane moved to bit 0
        case (size)
            icache_pkg::SIZE_BYTE: return word & 32'h0000_00ff;
            icache_pkg::SIZE_HALF: return addr[0] ? '0 : word & 32'h0000_ffff;
            default:               return (addr[1:0] == 2'b00) ? word : '0;
        endcase
    endfunction

    // reference lookup, fill and tree update for one access
    task automatic model_access(input logic [31:0] addr, output logic hit);
        logic [`ICACHE_TAG_W-1:0] tag;
        logic [`ICACHE_SET_W-1:0] set;
        logic [1:0]               way;
        tag = addr[31:10];
        set = addr[9:6];
        hit = 1'b0;
        way = 2'd0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        if (!hit) begin
            way = ref_tree[set][0] ? {1'b1, ref_tree[set][2]} : {1'b0, ref_tree[set][1]};
            for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
                if (!ref_valid[set][w]) way = 2'(w);  // lowest empty way first
            end
            ref_tag[set][way]   = tag;
            ref_valid[set][way] = 1'b1;
        end
        ref_tree[set][0]                = ~way[1];
        ref_tree[set][way[1] ? 2 : 1]   = ~way[0];
    endtask

    // one request and its response, rsp_ready withheld for a random stretch
    task automatic send_request(input logic [31:0] addr, input icache_pkg::access_size_e size,
                                input int stall_bits);
        int   waited;
        int   stall;
        logic hit;
        waited = 0;
        @(negedge ACLK);
        while (!req_ready && waited < TIMEOUT) begin
            @(negedge ACLK);
            waited++;
        end
        if (!req_ready) count_error({"timeout in ", test_name, " waiting for req_ready"});
        model_access(addr, hit);
        exp_hit   = hit;
        exp_data  = slice_of(addr, size);
        exp_line  = {addr[31:6], 6'd0};
        req       = '{addr: addr, size: size};
        req_valid = 1'b1;
        requests++;
        @(negedge ACLK);
        req_valid = 1'b0;
        stall     = int'(take_bits(stall_bits));
        waited    = 0;
        while (!rsp_ready && waited < TIMEOUT) begin
            @(negedge ACLK);
            waited++;
            if (rsp_valid && stall == 0) rsp_ready = 1'b1;
            else if (rsp_valid) stall--;
        end
        if (!rsp_ready) count_error({"timeout in ", test_name, " waiting for a response"});
        @(negedge ACLK);
        rsp_ready = 1'b0;
    endtask

    task automatic end_test();
        $display("test %-12s %0d errors", test_name, errors - err_mark);
        err_mark = errors;
        tests++;
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    a_reset_state: assert property (@(posedge ACLK) $rose(ARESETn) |->
        (req_ready && !rsp_valid && !l2_ar_valid && !busy))
        else count_error("outputs not at their idle values after reset");

    a_l2_addr: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (l2_ar_valid && l2_ar_ready) |-> (l2_ar_addr == exp_line))
        else count_error($sformatf("CHECK FAILED %s: l2 address expected %h actual %h",
            test_name, exp_line, $sampled(l2_ar_addr)));

    a_l2_count: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (rsp_valid && rsp_ready) |-> (ar_count == (exp_hit ? 0 : 1)))
        else count_error($sformatf("CHECK FAILED %s: l2 requests expected %0d actual %0d",
            test_name, exp_hit ? 0 : 1, $sampled(ar_count)));

    a_r_ready: assert property (@(posedge ACLK) disable iff (!ARESETn)
        l2_r_valid |-> l2_r_ready)
        else count_error({"l2 beat in ", test_name, " offered while l2_r_ready was low"});

    a_rsp_hit: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (rsp_valid && rsp_ready) |-> (rsp.hit == exp_hit))
        else count_error($sformatf("CHECK FAILED %s: hit flag expected %b actual %b",
            test_name, exp_hit, $sampled(rsp.hit)));

    a_rsp_data: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (rsp_valid && rsp_ready) |-> (rsp.data == exp_data))
        else count_error($sformatf("CHECK FAILED %s: rsp data expected %h actual %h",
            test_name, exp_data, $sampled(rsp.data)));

    a_hit_latency: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (req_valid && req_ready && exp_hit) |-> ##2 rsp_valid)
        else count_error({"hit in ", test_name, " not answered two cycles after acceptance"});

    a_rsp_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else count_error({"response in ", test_name, " changed while rsp_ready was low"});

    a_req_blocked: assert property (@(posedge ACLK) disable iff (!ARESETn)
        in_flight |-> !req_ready)
        else count_error({"req_ready high in ", test_name, " before the response ended"});

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0]              line_a;
        logic [31:0]              base;
        logic [`ICACHE_TAG_W-1:0] tag0;
        logic [31:0]              addrs [5];
        ARESETn   = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        exp_hit   = 1'b0;
        exp_data  = '0;
        exp_line  = '0;
        base      = '0;
        repeat (5) @(negedge ACLK);
        ARESETn = 1'b1;
        repeat (2) @(negedge ACLK);
        end_test();

        // first touch of a line, then repeats that must hit
        test_name = "cold_miss";
        line_a    = take_bits(26) << 6;
        send_request(line_a | 32'h24, icache_pkg::SIZE_WORD, 2);
        end_test();
        test_name = "hit";
        send_request(line_a | 32'h24, icache_pkg::SIZE_WORD, 0);
        send_request(line_a | 32'h3c, icache_pkg::SIZE_WORD, 2);
        end_test();

        test_name = "size";
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                send_request(line_a | 32'h18 | off, icache_pkg::access_size_e'(s), 1);
            end
        end
        end_test();

        // five tags compete for the four ways of set 9
        test_name = "plru";
        tag0      = `ICACHE_TAG_W'(take_bits(`ICACHE_TAG_W));
        for (int i = 0; i < 5; i++) begin
            addrs[i] = {tag0 + `ICACHE_TAG_W'(i), 4'h9, 6'd0};
            send_request(addrs[i], icache_pkg::SIZE_WORD, 1);
        end
        for (int i = 0; i < 24; i++) begin
            send_request(addrs[take_bits(3) % 5] | (take_bits(4) << 2), icache_pkg::SIZE_WORD, 1);
        end
        end_test();

        test_name = "backpressure";
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) base = take_bits(32);  // odd passes revisit the same line
            send_request(base, icache_pkg::access_size_e'(take_bits(2) % 3), 3);
        end
        end_test();

        $display("%0d tests, %0d requests, %0d errors", tests, requests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sim/l2_model.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module l2_model (
    input  logic                      ACLK,
    input  logic                      ar_valid,
    input  logic [`ICACHE_ADDR_W-1:0] ar_addr,
    output logic                      ar_ready,
    output logic                      r_valid,
    output logic [`ICACHE_DATA_W-1:0] r_data,
    output logic                      r_last
);

    logic [15:0]               lfsr;
    logic [`ICACHE_ADDR_W-1:0] line_addr;

    // galois lfsr, one step per gap bit
    function automatic int gap_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | int'(lfsr[0]);
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
        end
        return v;
    endfunction

    // outputs change on the falling edge only
    initial begin
        lfsr      = 16'd15;
        ar_ready  = 1'b0;
        r_valid   = 1'b0;
        r_data    = '0;
        r_last    = 1'b0;
        line_addr = '0;
        forever begin
            @(negedge ACLK);
            if (ar_valid === 1'b1) begin
                repeat (gap_bits(1)) @(negedge ACLK);  // sometimes a slow accept
                line_addr = ar_addr;
                ar_ready  = 1'b1;
                @(negedge ACLK);
                ar_ready = 1'b0;
                for (int beat = 0; beat < `ICACHE_WORDS; beat++) begin
                    repeat (gap_bits(2)) @(negedge ACLK);
                    r_valid = 1'b1;
                    r_data  = ~(line_addr + 4 * beat);  // inverse of the word's byte address
                    r_last  = (beat == `ICACHE_WORDS - 1);
                    @(negedge ACLK);
                    r_valid = 1'b0;
                    r_last  = 1'b0;
                end
            end
        end
    end

endmodule

// ==== logic/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_top (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  logic                      req_valid,
    input  icache_pkg::cpu_req_t      req,
    output logic                      req_ready,
    output logic                      rsp_valid,
    output icache_pkg::cpu_rsp_t      rsp,
    input  logic                      rsp_ready,
    output logic                      busy,
    output logic                      l2_ar_valid,
    output logic [`ICACHE_ADDR_W-1:0] l2_ar_addr,
    input  logic                      l2_ar_ready,
    input  logic                      l2_r_valid,
    input  logic [`ICACHE_DATA_W-1:0] l2_r_data,
    input  logic                      l2_r_last,
    output logic                      l2_r_ready
);

    icache_pkg::cpu_req_t      req_q;
    logic                      req_load, tag_we, plru_we, data_we, cnt_clear, refilling;
    logic                      hit, rsp_hit, last_beat;
    logic [`ICACHE_WAY_W-1:0]  hit_way, victim_way, access_way;
    logic [`ICACHE_WAYS-1:0]   all_valid;
    logic [`ICACHE_WORD_W-1:0] word_offset, ram_word;
    logic [`ICACHE_DATA_W-1:0] r_data;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            req_q <= '0;
        end else if (req_load) begin
            req_q <= req;
        end
    end

    assign l2_ar_addr = {req_q.addr.tag, req_q.addr.set, 6'b000000};  // line aligned
    assign access_way = refilling ? victim_way : hit_way;
    assign ram_word   = refilling ? word_offset : req_q.addr.word;
    assign rsp        = '{data: r_data, hit: rsp_hit};

    icache_fsm u_fsm (.*);

    refill_counter u_cnt (.ACLK, .ARESETn, .cnt_clear, .beat(data_we), .word_offset,
        .last_beat);

    tag_array u_tags (.ACLK, .ARESETn, .fields(req_q.addr), .tag_we, .fill_way(access_way),
        .hit, .hit_way, .all_valid);

    plru_tree u_plru (.ACLK, .ARESETn, .set(req_q.addr.set), .all_valid, .plru_we,
        .used_way(hit_way), .victim_way);

    line_data_ram u_ram (.ACLK, .data_we, .set(req_q.addr.set), .way(access_way),
        .word(ram_word), .w_data(l2_r_data), .size(req_q.size),
        .byte_off(req_q.addr.byte_off), .r_data);

    // L2 burst length must line up with the local beat count
    a_last_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (l2_r_valid && l2_r_ready) |-> (l2_r_last == last_beat));

endmodule

// ==== logic/line_data_ram.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module line_data_ram (
    input  logic                      ACLK,
    input  logic                      data_we,
    input  logic [`ICACHE_SET_W-1:0]  set,
    input  logic [`ICACHE_WAY_W-1:0]  way,
    input  logic [`ICACHE_WORD_W-1:0] word,
    input  logic [`ICACHE_DATA_W-1:0] w_data,
    input  icache_pkg::access_size_e  size,
    input  logic [1:0]                byte_off,
    output logic [`ICACHE_DATA_W-1:0] r_data
);

    localparam int DEPTH = `ICACHE_SETS * `ICACHE_WAYS * `ICACHE_WORDS;

    logic [`ICACHE_DATA_W-1:0] mem [DEPTH];
    logic [`ICACHE_DATA_W-1:0] rd_word;
    logic [$clog2(DEPTH)-1:0]  addr;

    assign addr = {set, way, word};  // 1024 words

    always_ff @(posedge ACLK) begin
        if (data_we) begin
            mem[addr] <= w_data;
        end
        rd_word <= mem[addr];  // one cycle read latency
    end

    ////////////////////////////////////////////////////////////
    // size and offset extraction, zero extended
    ////////////////////////////////////////////////////////////
    always_comb begin
        r_data = '0;
        case (size)
            icache_pkg::SIZE_BYTE: begin
                r_data = {24'b0, rd_word[8*byte_off +: 8]};
            end
            icache_pkg::SIZE_HALF: begin
                if (!byte_off[0]) r_data = {16'b0, rd_word[16*byte_off[1] +: 16]};
            end
            icache_pkg::SIZE_WORD: begin
                if (byte_off == 2'b00) r_data = rd_word;
            end
            default: r_data = '0;  // misaligned or unknown size gives zero
        endcase
    end

endmodule

// ==== logic/plru_tree.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module plru_tree (
    input  logic                     ACLK,
    input  logic                     ARESETn,
    input  logic [`ICACHE_SET_W-1:0] set,
    input  logic [`ICACHE_WAYS-1:0]  all_valid,
    input  logic                     plru_we,
    input  logic [`ICACHE_WAY_W-1:0] used_way,
    output logic [`ICACHE_WAY_W-1:0] victim_way
);

    // bit 0 root, bit 1 leaf of ways 0/1, bit 2 leaf of ways 2/3
    logic [`ICACHE_SETS-1:0][2:0] tree;
    logic [2:0]                   cur;

    assign cur = tree[set];

    ////////////////////////////////////////////////////////////
    // victim choice
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (cur[0]) begin
            victim_way = {1'b1, cur[2]};  // right pair
        end else begin
            victim_way = {1'b0, cur[1]};  // left pair
        end
        // an empty way wins over the tree, lowest index first
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!all_valid[w]) victim_way = `ICACHE_WAY_W'(w);
        end
    end

    ////////////////////////////////////////////////////////////
    // update, point the path away from the used way
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            tree <= '0;
        end else if (plru_we) begin
            if (used_way[1]) begin
                tree[set][0] <= 1'b0;
                tree[set][2] <= ~used_way[0];
            end else begin
                tree[set][0] <= 1'b1;
                tree[set][1] <= ~used_way[0];
            end
        end
    end

endmodule

// ==== logic/tag_array.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module tag_array (
    input  logic                     ACLK,
    input  logic                     ARESETn,
    input  icache_pkg::addr_fields_t fields,
    input  logic                     tag_we,
    input  logic [`ICACHE_WAY_W-1:0] fill_way,
    output logic                     hit,
    output logic [`ICACHE_WAY_W-1:0] hit_way,
    output logic [`ICACHE_WAYS-1:0]  all_valid
);

    logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid;
    logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0]  match;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            valid <= '0;
        end else if (tag_we) begin
            valid[fields.set][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (tag_we) begin
            tag_mem[fill_way][fields.set] <= fields.tag;
        end
    end

    ////////////////////////////////////////////////////////////
    // compare, all four ways in parallel
    ////////////////////////////////////////////////////////////
    assign all_valid = valid[fields.set];

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            match[w] = all_valid[w] && (tag_mem[w][fields.set] == fields.tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (match[w]) hit_way = `ICACHE_WAY_W'(w);
        end
    end

    assign hit = |match;

    // install always picks a missing tag, so a line never sits in two ways
    a_match_onehot: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $onehot0(match));

endmodule

// ==== logic/refill_counter.sv ====
`timescale 1ns/1ps
`include "icache_config.svh"

module refill_counter (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  logic                      cnt_clear,
    input  logic                      beat,
    output logic [`ICACHE_WORD_W-1:0] word_offset,
    output logic                      last_beat
);

    logic [`ICACHE_WORD_W-1:0] count;
    logic                      wrapped;  // full line seen since last clear

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            count   <= '0;
            wrapped <= 1'b0;
        end else if (cnt_clear) begin
            count   <= '0;
            wrapped <= 1'b0;
        end else if (beat) begin
            count <= count + 1'b1;  // wraps to 0 after the last word
            if (last_beat) wrapped <= 1'b1;
        end
    end

    assign word_offset = count;
    assign last_beat   = (count == `ICACHE_WORD_W'(`ICACHE_WORDS - 1));

    // a 17th beat would overwrite word 0 of the line
    a_no_extra_beat: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !(beat && wrapped));

endmodule

// ==== logic/icache_fsm.sv ====
`timescale 1ns/1ps

module icache_fsm (
    input  logic ACLK,
    input  logic ARESETn,
    input  logic req_valid,
    input  logic rsp_ready,
    input  logic hit,
    input  logic l2_ar_ready,
    input  logic l2_r_valid,
    input  logic last_beat,
    output logic req_ready,
    output logic rsp_valid,
    output logic rsp_hit,
    output logic busy,
    output logic l2_ar_valid,
    output logic l2_r_ready,
    output logic req_load,
    output logic tag_we,
    output logic plru_we,
    output logic data_we,
    output logic cnt_clear,
    output logic refilling
);

    icache_pkg::cache_state_e state;
    icache_pkg::cache_state_e state_nxt;
    logic                     miss_q;  // set by the first lookup of a request

    ////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state <= icache_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            icache_pkg::ST_IDLE: begin
                if (req_valid) state_nxt = icache_pkg::ST_LOOKUP;
            end
            icache_pkg::ST_LOOKUP: begin
                state_nxt = hit ? icache_pkg::ST_RESPOND : icache_pkg::ST_REFILL_REQ;
            end
            icache_pkg::ST_REFILL_REQ: begin
                if (l2_ar_ready) state_nxt = icache_pkg::ST_REFILL;
            end
            icache_pkg::ST_REFILL: begin
                // second lookup finds the freshly installed tag
                if (l2_r_valid && last_beat) state_nxt = icache_pkg::ST_LOOKUP;
            end
            icache_pkg::ST_RESPOND: begin
                if (rsp_ready) state_nxt = icache_pkg::ST_IDLE;
            end
            default: state_nxt = icache_pkg::ST_IDLE;
        endcase
    end

    // miss flag survives the refill so the response reports the original miss
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            miss_q <= 1'b0;
        end else if (req_load) begin
            miss_q <= 1'b0;
        end else if (state == icache_pkg::ST_LOOKUP && !hit) begin
            miss_q <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // strobes decoded from state
    ////////////////////////////////////////////////////////////
    assign req_ready   = (state == icache_pkg::ST_IDLE);
    assign req_load    = req_valid && req_ready;
    assign busy        = (state != icache_pkg::ST_IDLE);
    assign rsp_valid   = (state == icache_pkg::ST_RESPOND);
    assign rsp_hit     = !miss_q;
    assign l2_ar_valid = (state == icache_pkg::ST_REFILL_REQ);
    assign cnt_clear   = (state == icache_pkg::ST_REFILL_REQ);
    assign refilling   = (state == icache_pkg::ST_REFILL);
    assign l2_r_ready  = refilling;                      // every beat accepted
    assign data_we     = refilling && l2_r_valid;
    assign tag_we      = refilling && l2_r_valid && last_beat;
    assign plru_we     = (state == icache_pkg::ST_LOOKUP) && hit;  // entering respond

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    a_no_overlap: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !(rsp_valid && req_ready));

    a_ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (l2_ar_valid && !l2_ar_ready) |=> l2_ar_valid);

endmodule

// ==== logic/icache_pkg.sv ====
`include "icache_config.svh"

package icache_pkg;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_LOOKUP     = 3'd1,
        ST_REFILL_REQ = 3'd2,
        ST_REFILL     = 3'd3,
        ST_RESPOND    = 3'd4
    } cache_state_e;

    ////////////////////////////////////////////////////////////
    // request / response payloads
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]  tag;
        logic [`ICACHE_SET_W-1:0]  set;
        logic [`ICACHE_WORD_W-1:0] word;
        logic [`ICACHE_ADDR_W-`ICACHE_TAG_W-`ICACHE_SET_W-`ICACHE_WORD_W-1:0] byte_off;
    } addr_fields_t;  // 32 bits

    typedef struct packed {
        addr_fields_t addr;
        access_size_e size;
    } cpu_req_t;  // 34 bits

    typedef struct packed {
        logic [`ICACHE_DATA_W-1:0] data;
        logic                      hit;  // low when the line had to be fetched
    } cpu_rsp_t;  // 33 bits

endpackage

// ==== include/icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////
`define ICACHE_ADDR_W   32
`define ICACHE_DATA_W   32

////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////
`define ICACHE_SETS     16
`define ICACHE_WAYS     4
`define ICACHE_WORDS    16  // words per 64-byte line

// address split, tag + set + word + byte = 32
`define ICACHE_TAG_W    22
`define ICACHE_SET_W    4
`define ICACHE_WAY_W    2
`define ICACHE_WORD_W   4

`endif
